// ==== source/alloc_pkg.sv ====
// Pool-wide definitions for the pointer allocator
// The pool size must be a power of two, because the scan index wraps by overflow
// cnt_t is one bit wider than a pointer so it can hold a full pool

package alloc_pkg;

    // ------------------------------
    // Pool geometry
    // ------------------------------

    // Number of pointers managed by the bit vector
    localparam int NUM_PTRS = 64;

    // Bits in a pointer index
    localparam int PTR_WID = $clog2(NUM_PTRS);

    // ------------------------------
    // Types
    // ------------------------------

    // Pointer index into the pool
    typedef logic [PTR_WID-1:0] ptr_t;

    // Pointer count, 0 to NUM_PTRS inclusive
    typedef logic [PTR_WID:0] cnt_t;

    // Double-free error counter, saturates at all ones
    typedef logic [7:0] err_cnt_t;

endpackage : alloc_pkg

// ==== source/alloc_reg_pkg.sv ====
// Register map of the allocator control block
// Word addressed, one 16-bit register per address
// Unused addresses read as zero and ignore writes

package alloc_reg_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------

    typedef logic [3:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // ------------------------------
    // Address map
    // ------------------------------

    // Control, read/write
    localparam reg_addr_t ADDR_CTRL        = 4'd0;
    // Status, read only
    localparam reg_addr_t ADDR_STATUS      = 4'd1;
    // Pointers currently held by requesters, read only
    localparam reg_addr_t ADDR_OUTSTANDING = 4'd2;
    // Double-free count; any write clears it
    localparam reg_addr_t ADDR_ERR_CNT     = 4'd3;

    // ------------------------------
    // Bit positions
    // ------------------------------

    // Soft reset, self-clearing, reads as 0
    localparam int CTRL_SRST_BIT    = 0;
    localparam int CTRL_EN_BIT      = 1;
    localparam int CTRL_SCAN_EN_BIT = 2;

    localparam int STATUS_INIT_DONE_BIT = 0;

endpackage : alloc_reg_pkg

// ==== source/alloc_ptr_fifo.sv ====
// Show-ahead pointer FIFO, head_ptr is valid whenever empty is low
// A push while full and a pop while empty are ignored
// Flush wins over push and pop in the same cycle

`timescale 1ns/1ps

module alloc_ptr_fifo #(
    parameter int DEPTH = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            push,
    input  alloc_pkg::ptr_t push_ptr,
    input  logic            pop,
    output alloc_pkg::ptr_t head_ptr,
    output logic            empty,
    output logic            full
);

    // Index and occupancy widths
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

    alloc_pkg::ptr_t mem [DEPTH];

    logic [AW-1:0] wr_idx;
    logic [AW-1:0] rd_idx;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty    = (count == '0);
    assign full     = (count == CW'(DEPTH));
    assign head_ptr = mem[rd_idx];

    // Storage, written at the tail
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_idx] <= push_ptr;
        end
    end

    // Ring indices and occupancy
    // Wrap by compare so any depth works
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_idx <= (wr_idx == LAST) ? '0 : wr_idx + 1'b1;
            end
            if (do_pop) begin
                rd_idx <= (rd_idx == LAST) ? '0 : rd_idx + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : alloc_ptr_fifo

// ==== source/alloc_bv_scan.sv ====
// Bit vector core, one bit per pointer, set while the pointer is in use
// Init clears the vector one bit per cycle, NUM_PTRS cycles in all
// At most one found pointer waits between the scan and the allocation queue

`timescale 1ns/1ps

module alloc_bv_scan (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            soft_rst,
    input  logic            en,
    input  logic            scan_en,
    input  logic            aq_full,
    output logic            aq_push,
    output alloc_pkg::ptr_t aq_ptr,
    input  logic            dq_empty,
    output logic            dq_pop,
    input  alloc_pkg::ptr_t dq_ptr,
    output logic            init_done,
    output logic            dbl_free
);

    // Last index of the pool, end of init
    localparam alloc_pkg::ptr_t LAST_IDX = alloc_pkg::ptr_t'(alloc_pkg::NUM_PTRS - 1);

    typedef enum logic {
        ST_INIT,
        ST_RUN
    } state_t;

    state_t state;

    // Shared index: clear pointer during init, scan position during run
    alloc_pkg::ptr_t idx;

    // 1 = pointer in use or waiting in the allocation queue
    logic [alloc_pkg::NUM_PTRS-1:0] bv;

    logic running;
    logic init_clr;
    logic scan_go;
    logic scan_hit;
    logic dq_bit;

    // ------------------------------
    // Per-cycle decisions
    // ------------------------------

    // The soft-reset pulse freezes all vector activity
    assign running  = (state == ST_RUN) && !soft_rst;
    assign init_clr = (state == ST_INIT) && !soft_rst;

    // Examine one pointer only while the queue has room
    assign scan_go  = running && en && scan_en && !aq_full;
    assign scan_hit = scan_go && !bv[idx];

    // Retire whatever is waiting, independent of the enables
    assign dq_pop = running && !dq_empty;
    assign dq_bit = bv[dq_ptr];

    // Drops in the soft-reset cycle itself, so no transfer slips through
    assign init_done = running;

    // ------------------------------
    // Control state
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_INIT;
            idx      <= '0;
            aq_push  <= 1'b0;
            dbl_free <= 1'b0;
        end else if (soft_rst) begin
            // Queues are flushed by the same pulse, drop the waiting pointer too
            state    <= ST_INIT;
            idx      <= '0;
            aq_push  <= 1'b0;
            dbl_free <= 1'b0;
        end else begin
            // Returned pointer whose bit was already clear
            dbl_free <= dq_pop && !dq_bit;
            case (state)
                ST_INIT: begin
                    // Index wraps to 0 at the end, so the first scan starts at 0
                    idx <= idx + 1'b1;
                    if (idx == LAST_IDX) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (scan_go) begin
                        idx <= idx + 1'b1;
                    end
                    // A waiting pointer holds while the queue is full
                    if (scan_hit) begin
                        aq_push <= 1'b1;
                    end else if (!aq_full) begin
                        aq_push <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_INIT;
                end
            endcase
        end
    end

    // ------------------------------
    // Bit vector and found pointer
    // ------------------------------

    // Scan sets only clear bits and retire clears only set bits,
    // so the two never fight over one bit in a cycle
    always_ff @(posedge clk) begin
        if (init_clr) begin
            bv[idx] <= 1'b0;
        end
        if (scan_hit) begin
            bv[idx] <= 1'b1;
            aq_ptr  <= idx;
        end
        if (dq_pop && dq_bit) begin
            bv[dq_ptr] <= 1'b0;
        end
    end

endmodule : alloc_bv_scan

// ==== source/alloc_regs.sv ====
// Register block of the allocator, strobe bus with no wait states
// Writes act at the sampling edge, read data follows reg_rd by one cycle
// Outstanding count assumes requesters only free pointers they hold

`timescale 1ns/1ps

module alloc_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  alloc_reg_pkg::reg_addr_t reg_addr,
    input  alloc_reg_pkg::reg_data_t reg_wdata,
    output alloc_reg_pkg::reg_data_t reg_rdata,
    output logic                     reg_rvalid,
    output logic                     ctrl_reset,
    output logic                     ctrl_en,
    output logic                     ctrl_scan_en,
    input  logic                     init_done,
    input  logic                     dbl_free,
    input  logic                     alloc_fire,
    input  logic                     dealloc_fire
);

    logic                     wr_ctrl;
    logic                     wr_err;
    alloc_pkg::cnt_t          outstanding;
    alloc_pkg::err_cnt_t      err_cnt;
    alloc_reg_pkg::reg_data_t rd_mux;

    // Address decode
    assign wr_ctrl = reg_wr && (reg_addr == alloc_reg_pkg::ADDR_CTRL);
    assign wr_err  = reg_wr && (reg_addr == alloc_reg_pkg::ADDR_ERR_CNT);

    // ------------------------------
    // Control bits
    // ------------------------------

    // Soft reset is high for exactly one cycle after the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_reset   <= 1'b0;
            ctrl_en      <= 1'b0;
            ctrl_scan_en <= 1'b0;
        end else if (wr_ctrl) begin
            ctrl_reset   <= reg_wdata[alloc_reg_pkg::CTRL_SRST_BIT];
            ctrl_en      <= reg_wdata[alloc_reg_pkg::CTRL_EN_BIT];
            ctrl_scan_en <= reg_wdata[alloc_reg_pkg::CTRL_SCAN_EN_BIT];
        end else begin
            ctrl_reset <= 1'b0;
        end
    end

    // ------------------------------
    // Counters
    // ------------------------------

    // Pointers held outside the allocator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else if (ctrl_reset) begin
            outstanding <= '0;
        end else begin
            case ({alloc_fire, dealloc_fire})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Double frees, saturating, kept across soft reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_cnt <= '0;
        end else if (wr_err) begin
            err_cnt <= '0;
        end else if (dbl_free && (err_cnt != '1)) begin
            err_cnt <= err_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Read path
    // ------------------------------

    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            alloc_reg_pkg::ADDR_CTRL: begin
                // Soft reset bit reads back as 0
                rd_mux[alloc_reg_pkg::CTRL_EN_BIT]      = ctrl_en;
                rd_mux[alloc_reg_pkg::CTRL_SCAN_EN_BIT] = ctrl_scan_en;
            end
            alloc_reg_pkg::ADDR_STATUS: begin
                rd_mux[alloc_reg_pkg::STATUS_INIT_DONE_BIT] = init_done;
            end
            alloc_reg_pkg::ADDR_OUTSTANDING: rd_mux = alloc_reg_pkg::reg_data_t'(outstanding);
            alloc_reg_pkg::ADDR_ERR_CNT:     rd_mux = alloc_reg_pkg::reg_data_t'(err_cnt);
            default:                         rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rvalid <= 1'b0;
            reg_rdata  <= '0;
        end else begin
            reg_rvalid <= reg_rd;
            if (reg_rd) begin
                reg_rdata <= rd_mux;
            end
        end
    end

endmodule : alloc_regs

// ==== source/alloc_bv.sv ====
// Bit-vector pointer allocator with register control, pool of alloc_pkg::NUM_PTRS
// Both ports are held off until init is done and the core is enabled
// Queue depths only shape burst behaviour, the pool size is fixed

`timescale 1ns/1ps

module alloc_bv #(
    // Burst of allocations served without waiting on the scan
    parameter int ALLOC_Q_DEPTH   = 16,
    // Burst of frees accepted ahead of the retire
    parameter int DEALLOC_Q_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // Allocate port
    input  logic                     alloc_req,
    output logic                     alloc_rdy,
    output alloc_pkg::ptr_t          alloc_ptr,

    // Deallocate port
    input  logic                     dealloc_req,
    output logic                     dealloc_rdy,
    input  alloc_pkg::ptr_t          dealloc_ptr,

    // Register bus
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  alloc_reg_pkg::reg_addr_t reg_addr,
    input  alloc_reg_pkg::reg_data_t reg_wdata,
    output alloc_reg_pkg::reg_data_t reg_rdata,
    output logic                     reg_rvalid,

    output logic                     init_done
);

    // ------------------------------
    // Signals
    // ------------------------------
    logic            ctrl_reset;
    logic            ctrl_en;
    logic            ctrl_scan_en;
    logic            dbl_free;

    logic            alloc_fire;
    logic            dealloc_fire;

    logic            aq_push;
    alloc_pkg::ptr_t aq_ptr;
    logic            aq_empty;
    logic            aq_full;

    logic            dq_pop;
    alloc_pkg::ptr_t dq_ptr;
    logic            dq_empty;
    logic            dq_full;

    // Ready gating and transfer strobes
    assign alloc_rdy    = ctrl_en && init_done && !aq_empty;
    assign dealloc_rdy  = ctrl_en && init_done && !dq_full;
    assign alloc_fire   = alloc_req && alloc_rdy;
    assign dealloc_fire = dealloc_req && dealloc_rdy;

    // ------------------------------
    // Register block
    // ------------------------------
    alloc_regs i_alloc_regs (
        .clk,
        .rst_n,
        .reg_wr,
        .reg_rd,
        .reg_addr,
        .reg_wdata,
        .reg_rdata,
        .reg_rvalid,
        .ctrl_reset,
        .ctrl_en,
        .ctrl_scan_en,
        .init_done,
        .dbl_free,
        .alloc_fire,
        .dealloc_fire
    );

    // ------------------------------
    // Bit vector, init and scan
    // ------------------------------
    alloc_bv_scan i_alloc_bv_scan (
        .clk,
        .rst_n,
        .soft_rst ( ctrl_reset ),
        .en       ( ctrl_en ),
        .scan_en  ( ctrl_scan_en ),
        .aq_full,
        .aq_push,
        .aq_ptr,
        .dq_empty,
        .dq_pop,
        .dq_ptr,
        .init_done,
        .dbl_free
    );

    // ------------------------------
    // Queues
    // ------------------------------

    // Free pointers found by the scan, head goes out on alloc_ptr
    alloc_ptr_fifo #(
        .DEPTH ( ALLOC_Q_DEPTH )
    ) i_alloc_q (
        .clk,
        .rst_n,
        .flush    ( ctrl_reset ),
        .push     ( aq_push ),
        .push_ptr ( aq_ptr ),
        .pop      ( alloc_fire ),
        .head_ptr ( alloc_ptr ),
        .empty    ( aq_empty ),
        .full     ( aq_full )
    );

    // Returned pointers waiting for retire
    alloc_ptr_fifo #(
        .DEPTH ( DEALLOC_Q_DEPTH )
    ) i_dealloc_q (
        .clk,
        .rst_n,
        .flush    ( ctrl_reset ),
        .push     ( dealloc_fire ),
        .push_ptr ( dealloc_ptr ),
        .pop      ( dq_pop ),
        .head_ptr ( dq_ptr ),
        .empty    ( dq_empty ),
        .full     ( dq_full )
    );

endmodule : alloc_bv

// ==== sim/alloc_bv_sva.sv ====
// Port and init assertions for the allocator top level, bound to alloc_bv
// All properties sample on the rising edge and are off while rst_n is low

`timescale 1ns/1ps

module alloc_bv_sva (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     alloc_req,
    input logic                     alloc_rdy,
    input alloc_pkg::ptr_t          alloc_ptr,
    input logic                     dealloc_rdy,
    input logic                     dq_empty,
    input logic                     reg_wr,
    input alloc_reg_pkg::reg_addr_t reg_addr,
    input alloc_reg_pkg::reg_data_t reg_wdata,
    input logic                     init_done
);

    // ------------------------------
    // Allocate port
    // ------------------------------

    // Nothing offered during init, and the queue is still empty when init ends
    rdy_before_init: assert property (@(posedge clk) disable iff (!rst_n)
        !init_done |=> !alloc_rdy)
        else $error("alloc_rdy high during init or right at its end");

    // Offered head holds until taken
    ptr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_rdy && !alloc_req |=> $stable(alloc_ptr))
        else $error("alloc_ptr changed while offered and not taken");

    // ------------------------------
    // Deallocate port and init
    // ------------------------------

    // A refused request never lands in an empty retire queue
    no_dealloc_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !dealloc_rdy && dq_empty |=> dq_empty)
        else $error("dealloc accepted while dealloc_rdy is low");

    // Soft reset pulse drops init_done straight away
    srst_drops_init: assert property (@(posedge clk) disable iff (!rst_n)
        reg_wr && (reg_addr == alloc_reg_pkg::ADDR_CTRL) &&
        reg_wdata[alloc_reg_pkg::CTRL_SRST_BIT] |=> !init_done)
        else $error("init_done still high after a soft-reset write");

endmodule : alloc_bv_sva

bind alloc_bv alloc_bv_sva i_alloc_bv_sva (
    .clk          ( clk ),
    .rst_n        ( rst_n ),
    .alloc_req    ( alloc_req ),
    .alloc_rdy    ( alloc_rdy ),
    .alloc_ptr    ( alloc_ptr ),
    .dealloc_rdy  ( dealloc_rdy ),
    .dq_empty     ( dq_empty ),
    .reg_wr       ( reg_wr ),
    .reg_addr     ( reg_addr ),
    .reg_wdata    ( reg_wdata ),
    .init_done    ( init_done )
);

// ==== sim/alloc_bv_tb.sv ====
// Vector-driven testbench for the pointer allocator
// Reads sim/alloc_vectors.txt relative to the project root
// The model tracks held pointers and the outstanding count
// Idle is read from the retire queue inside the DUT

`timescale 1ns/1ps

module alloc_bv_tb;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     alloc_req;
    logic                     alloc_rdy;
    alloc_pkg::ptr_t          alloc_ptr;
    logic                     dealloc_req;
    logic                     dealloc_rdy;
    alloc_pkg::ptr_t          dealloc_ptr;
    logic                     reg_wr;
    logic                     reg_rd;
    alloc_reg_pkg::reg_addr_t reg_addr;
    alloc_reg_pkg::reg_data_t reg_wdata;
    alloc_reg_pkg::reg_data_t reg_rdata;
    logic                     reg_rvalid;
    logic                     init_done;

    // Vector storage, one entry per command line
    string cmd_q[$];
    string name_q[$];
    int    arg0_q[$];
    int    arg1_q[$];

    // Reference model
    alloc_pkg::ptr_t held_q[$];
    logic            held_map [alloc_pkg::NUM_PTRS];
    alloc_pkg::cnt_t out_cnt;
    logic [31:0]     lcg_state = 32'h2cc9;

    int cycle_cnt   = 0;
    int cycle_limit = 0;

    alloc_bv #(
        .ALLOC_Q_DEPTH   ( 16 ),
        .DEALLOC_Q_DEPTH ( 8 )
    ) dut0 (
        .clk         ( clk ),
        .rst_n       ( rst_n ),
        .alloc_req   ( alloc_req ),
        .alloc_rdy   ( alloc_rdy ),
        .alloc_ptr   ( alloc_ptr ),
        .dealloc_req ( dealloc_req ),
        .dealloc_rdy ( dealloc_rdy ),
        .dealloc_ptr ( dealloc_ptr ),
        .reg_wr      ( reg_wr ),
        .reg_rd      ( reg_rd ),
        .reg_addr    ( reg_addr ),
        .reg_wdata   ( reg_wdata ),
        .reg_rdata   ( reg_rdata ),
        .reg_rvalid  ( reg_rvalid ),
        .init_done   ( init_done )
    );

    // 100 ns period
    always #50 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // ------------------------------
    // Checks and failure
    // ------------------------------

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_ptr(input string name, input alloc_pkg::ptr_t exp,
                             input alloc_pkg::ptr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input alloc_reg_pkg::reg_data_t exp,
                             input alloc_reg_pkg::reg_data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_cnt(input string name, input alloc_pkg::cnt_t exp,
                             input alloc_pkg::cnt_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ------------------------------
    // Bus and port drivers
    // ------------------------------

    task automatic reg_write(input alloc_reg_pkg::reg_addr_t addr,
                             input alloc_reg_pkg::reg_data_t data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    // Read data is due exactly one cycle after the strobe
    task automatic reg_read(input alloc_reg_pkg::reg_addr_t addr,
                            output alloc_reg_pkg::reg_data_t data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_rd <= 1'b0;
        @(negedge clk);
        if (!reg_rvalid) begin
            $display("reg_rvalid missing one cycle after a read of address %0d", addr);
            abort_run();
        end
        data = reg_rdata;
    endtask

    task automatic wait_init(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!init_done) begin
            // Neither port may offer a handshake before init has finished
            if (alloc_rdy || dealloc_rdy) begin
                $display("%s: port ready while init_done is low", name);
                abort_run();
            end
            n++;
            if (n > alloc_pkg::NUM_PTRS + 2) begin
                $display("%s: init_done did not rise within %0d cycles", name,
                         alloc_pkg::NUM_PTRS + 2);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    // Idle once the retire queue has drained and the error pulse has landed
    task automatic wait_idle();
        do @(negedge clk); while (!dut0.dq_empty);
        repeat (3) @(posedge clk);
    endtask

    // One transfer, pointer must not be held by the model
    task automatic alloc_one(input string name, output alloc_pkg::ptr_t p);
        @(posedge clk);
        alloc_req <= 1'b1;
        do @(negedge clk); while (!alloc_rdy);
        p = alloc_ptr;
        @(posedge clk);
        alloc_req <= 1'b0;
        if (held_map[p]) begin
            $display("%s: pointer %0d handed out while still held", name, p);
            abort_run();
        end
        held_map[p] = 1'b1;
        held_q.push_back(p);
        out_cnt = out_cnt + 1'b1;
    endtask

    // Counter follows every acceptance, double frees included
    task automatic free_ptr(input alloc_pkg::ptr_t p);
        @(posedge clk);
        dealloc_req <= 1'b1;
        dealloc_ptr <= p;
        do @(negedge clk); while (!dealloc_rdy);
        @(posedge clk);
        dealloc_req <= 1'b0;
        held_map[p] = 1'b0;
        out_cnt = out_cnt - 1'b1;
    endtask

    task automatic clear_model();
        held_q.delete();
        foreach (held_map[k]) held_map[k] = 1'b0;
        out_cnt = '0;
    endtask

    // Random mix of allocs and frees with gaps of 0 to 3 cycles
    task automatic churn(input string name, input int n);
        alloc_pkg::ptr_t p;
        int idx;
        for (int i = 0; i < n; i++) begin
            lcg_state = lcg_next(lcg_state);
            repeat (lcg_state[17:16]) @(posedge clk);
            if (held_q.size() > 0 && (lcg_state[20] || held_q.size() == alloc_pkg::NUM_PTRS)) begin
                idx = int'(lcg_state[30:8]) % held_q.size();
                p = held_q[idx];
                held_q.delete(idx);
                free_ptr(p);
            end else begin
                alloc_one(name, p);
            end
        end
    endtask

    // ------------------------------
    // Vector file and dispatch
    // ------------------------------

    task automatic load_vectors();
        int    fd;
        int    rc;
        string line;
        string c;
        string nm;
        int    x;
        int    y;
        fd = $fopen("sim/alloc_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file sim/alloc_vectors.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                rc = $sscanf(line, "%s %s %h %h", c, nm, x, y);
                if (rc != 4) begin
                    $display("Malformed vector line: %s", line);
                    abort_run();
                end
                cmd_q.push_back(c);
                name_q.push_back(nm);
                arg0_q.push_back(x);
                arg1_q.push_back(y);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input int i);
        alloc_pkg::ptr_t          p;
        alloc_reg_pkg::reg_data_t d;
        string                    nm;
        nm = name_q[i];
        case (cmd_q[i])
            "WR": begin
                reg_write(alloc_reg_pkg::reg_addr_t'(arg0_q[i]),
                          alloc_reg_pkg::reg_data_t'(arg1_q[i]));
                // Soft reset drops every held pointer
                if (arg0_q[i] == alloc_reg_pkg::ADDR_CTRL &&
                    arg1_q[i][alloc_reg_pkg::CTRL_SRST_BIT]) begin
                    clear_model();
                end
            end
            "RD": begin
                reg_read(alloc_reg_pkg::reg_addr_t'(arg0_q[i]), d);
                check_reg(nm, alloc_reg_pkg::reg_data_t'(arg1_q[i]), d);
            end
            "OS": begin
                reg_read(alloc_reg_pkg::ADDR_OUTSTANDING, d);
                check_cnt(nm, out_cnt, alloc_pkg::cnt_t'(d));
            end
            "WI": wait_init(nm);
            "ID": wait_idle();
            "AL": begin
                // First pointer ff means order is not checked
                for (int k = 0; k < arg0_q[i]; k++) begin
                    alloc_one(nm, p);
                    if (arg1_q[i] != 'hff) begin
                        check_ptr(nm, alloc_pkg::ptr_t'(arg1_q[i] + k), p);
                    end
                end
            end
            "FR": begin
                for (int k = 0; k < arg0_q[i]; k++) begin
                    p = held_q.pop_front();
                    free_ptr(p);
                end
            end
            "DB": begin
                p = held_q.pop_front();
                free_ptr(p);
                free_ptr(p);
            end
            "RG": churn(nm, arg0_q[i]);
            "AF": begin
                while (held_q.size() < alloc_pkg::NUM_PTRS) begin
                    alloc_one(nm, p);
                end
            end
            "NR": begin
                repeat (arg0_q[i]) begin
                    @(negedge clk);
                    if (alloc_rdy) begin
                        $display("%s: alloc_rdy high with the whole pool held", nm);
                        abort_run();
                    end
                end
            end
            default: begin
                $display("Unknown vector command %s", cmd_q[i]);
                abort_run();
            end
        endcase
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        rst_n       = 1'b0;
        alloc_req   = 1'b0;
        dealloc_req = 1'b0;
        dealloc_ptr = '0;
        reg_wr      = 1'b0;
        reg_rd      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        clear_model();
        load_vectors();
        // Init time plus 20 cycles per command line, doubled
        cycle_limit = (alloc_pkg::NUM_PTRS + 20 * cmd_q.size()) * 2;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        foreach (cmd_q[i]) begin
            run_vector(i);
        end
        repeat (2) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule : alloc_bv_tb

// ==== sim/alloc_vectors.txt ====
# Columns: command test_name arg0 arg1, both args in hex
# WR addr data | RD addr expect | OS | WI | ID | AL count first (ff any) | FR count | DB | RG count | AF | NR cycles
RD reset_ctrl 0 0
RD reset_status 1 0
RD reset_outst 2 0
RD reset_err 3 0
WR enable 0 6
WI init_wait 0 0
RD init_status 1 1
RD ctrl_readback 0 6
AL first_fill 8 0
OS fill_count 0 0
FR fill_free 4 0
RG churn_a 12 0
RG churn_b 12 0
RG churn_c 12 0
RG churn_d 12 0
RG churn_e 12 0
ID churn_idle 0 0
OS churn_count 0 0
AF fill_all 0 0
NR pool_empty a 0
OS full_count 0 0
WR scan_off 0 2
DB double_free 0 0
ID dbl_idle 0 0
RD err_one 3 1
OS dbl_count 0 0
WR err_clear 3 0
RD err_zero 3 0
WR soft_reset 0 7
RD srst_outst 2 0
WI reinit_wait 0 0
RD srst_ctrl 0 6
AL refill 4 0

// ==== verilog.f ====
source/alloc_pkg.sv
source/alloc_reg_pkg.sv
source/alloc_ptr_fifo.sv
source/alloc_bv_scan.sv
source/alloc_regs.sv
source/alloc_bv.sv
sim/alloc_bv_sva.sv
sim/alloc_bv_tb.sv
